/* design/hostPkg.sv */
package hostPkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Bus widths
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // One byte on the CPU data bus
    localparam int dataWidth = 8;

    // Full CPU address bus
    localparam int addrWidth = 16;

    // Index into one 512-byte memory
    localparam int memIndexWidth = 9;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Serial timing
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // pll_clk cycles per serial bit
    localparam int serialBitCycles = 8;

    // Width of the bit-period counter
    localparam int bitTimerWidth = $clog2(serialBitCycles);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Bus cycle classification
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // One value per kind of CPU bus cycle
    typedef enum logic [2:0] {
        idle     = 3'd0,
        memRead  = 3'd1,
        memWrite = 3'd2,
        ioRead   = 3'd3,
        ioWrite  = 3'd4,
        intAck   = 3'd5
    } busCycle;

endpackage

/* design/memMapPkg.sv */
package memMapPkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Memory and IO map
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Address bit 9 picks RAM when set, ROM when clear
    localparam int romSelectBit = 9;

    // IO high byte for writes to the serial port
    localparam logic [7:0] ioTxPage = 8'h00;

    // IO high byte for reading the serial busy flag
    localparam logic [7:0] ioStatusPage = 8'h02;

    // Byte placed on the bus during interrupt acknowledge
    localparam logic [7:0] intVector = 8'h80;

    // ROM byte is the inverted low byte with 0x5A XORed in for the upper 256 bytes
    function automatic logic [hostPkg::dataWidth-1:0] romByte(
        input logic [hostPkg::memIndexWidth-1:0] index
    );
        return ~index[7:0] ^ (index[8] ? 8'h5A : 8'h00);
    endfunction

endpackage

/* design/busCycleDecode.sv */
`timescale 1ns/1ps

module busCycleDecode
(
    input  logic                               pll_clk,
    input  logic                               rst,
    input  logic                               nM1,
    input  logic                               nMreq,
    input  logic                               nIorq,
    input  logic                               nRd,
    input  logic                               nWr,
    input  logic [hostPkg::addrWidth-1:0]      address,
    input  logic [hostPkg::dataWidth-1:0]      writeData,
    output hostPkg::busCycle                   cycleType,
    output logic                               ramSelect,
    output logic [hostPkg::memIndexWidth-1:0]  memIndex,
    output logic [hostPkg::dataWidth-1:0]      ioPage,
    output logic [hostPkg::dataWidth-1:0]      wrByte,
    output logic                               ramWrite,
    output logic                               txWrite
);
    import hostPkg::*;
    import memMapPkg::*;

    busCycle nextCycle;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Strobe pattern to cycle type
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Bit order is nM1, nMreq, nIorq, nRd, nWr
    always_comb
    begin
        casez ({nM1, nMreq, nIorq, nRd, nWr})
            // M1 with IORQ is the interrupt acknowledge
            5'b0?0??: nextCycle = intAck;
            5'b?010?: nextCycle = memRead;
            5'b?01?0: nextCycle = memWrite;
            5'b1100?: nextCycle = ioRead;
            5'b110?0: nextCycle = ioWrite;
            default:  nextCycle = idle;
        endcase
    end

    // Control state and write strobes
    always_ff @(posedge pll_clk)
    begin
        if (rst)
        begin
            cycleType <= idle;
            ramWrite  <= 1'b0;
            txWrite   <= 1'b0;
        end
        else
        begin
            cycleType <= nextCycle;
            // Only RAM takes writes, ROM space is silently ignored
            ramWrite  <= (nextCycle == memWrite) && address[romSelectBit];
            txWrite   <= (nextCycle == ioWrite) && (address[15:8] == ioTxPage);
        end
    end

    // Address fields and write byte
    always_ff @(posedge pll_clk)
    begin
        ramSelect <= address[romSelectBit];
        memIndex  <= address[memIndexWidth-1:0];
        ioPage    <= address[15:8];
        wrByte    <= writeData;
    end

endmodule

/* design/memoryBlock.sv */
`timescale 1ns/1ps

module memoryBlock
(
    input  logic                               pll_clk,
    input  logic [hostPkg::memIndexWidth-1:0]  memIndex,
    input  logic                               ramSelect,
    input  logic                               ramWrite,
    input  logic [hostPkg::dataWidth-1:0]      wrByte,
    output logic [hostPkg::dataWidth-1:0]      memByte
);
    import hostPkg::*;
    import memMapPkg::*;

    localparam int memDepth = 1 << memIndexWidth;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Storage
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Each bank holds 512 bytes and mirrors across the upper address bits
    logic [dataWidth-1:0] ramArray [memDepth];
    logic [dataWidth-1:0] romArray [memDepth];

    // ROM image built from the content rule
    initial
    begin
        for (int i = 0; i < memDepth; i++)
        begin
            romArray[i] = romByte(memIndexWidth'(i));
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Write port
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Write lands one edge after the bus cycle was sampled
    always_ff @(posedge pll_clk)
    begin
        if (ramWrite)
        begin
            ramArray[memIndex] <= wrByte;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Read port
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Both banks are read at the same index
    // ramSelect picks which one gets registered
    // A read just after a write sees the updated array here
    always_ff @(posedge pll_clk)
    begin
        if (ramSelect)
        begin
            memByte <= ramArray[memIndex];
        end
        else
        begin
            memByte <= romArray[memIndex];
        end
    end

endmodule

/* design/serialTx.sv */
`timescale 1ns/1ps

module serialTx
(
    input  logic                          pll_clk,
    input  logic                          rst,
    input  logic                          txWrite,
    input  logic [hostPkg::dataWidth-1:0] wrByte,
    output logic                          serialOut,
    output logic                          busy
);
    import hostPkg::*;

    // Frame phases
    typedef enum logic [1:0] {
        txIdle  = 2'd0,
        txStart = 2'd1,
        txData  = 2'd2,
        txStop  = 2'd3
    } txState;

    txState                   state;
    logic [bitTimerWidth-1:0] bitTimer;
    logic [2:0]               bitIndex;
    logic [dataWidth-1:0]     shiftReg;
    logic                     bitDone;
    logic                     loadByte;
    logic                     shiftBit;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Bit timing
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Last pll_clk cycle of the current bit
    assign bitDone = (bitTimer == bitTimerWidth'(serialBitCycles - 1));

    // Writes while a frame is going out are dropped
    assign loadByte = txWrite && (state == txIdle);

    // Next data bit leaves the shifter at the end of start and data bits
    assign shiftBit = bitDone && ((state == txStart) ||
                                  ((state == txData) && (bitIndex != 3'd7)));

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Frame FSM
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge pll_clk)
    begin
        if (rst)
        begin
            state     <= txIdle;
            bitTimer  <= '0;
            bitIndex  <= '0;
            serialOut <= 1'b1;
            busy      <= 1'b0;
        end
        else
        begin
            case (state)
                txIdle:
                begin
                    bitTimer <= '0;
                    if (loadByte)
                    begin
                        // Start bit goes out together with busy
                        state     <= txStart;
                        serialOut <= 1'b0;
                        busy      <= 1'b1;
                    end
                end
                txStart:
                begin
                    bitTimer <= bitTimer + 1'b1;
                    if (bitDone)
                    begin
                        state     <= txData;
                        bitIndex  <= '0;
                        serialOut <= shiftReg[0];
                    end
                end
                txData:
                begin
                    bitTimer <= bitTimer + 1'b1;
                    if (bitDone)
                    begin
                        if (bitIndex == 3'd7)
                        begin
                            state     <= txStop;
                            serialOut <= 1'b1;
                        end
                        else
                        begin
                            bitIndex  <= bitIndex + 1'b1;
                            serialOut <= shiftReg[0];
                        end
                    end
                end
                txStop:
                begin
                    bitTimer <= bitTimer + 1'b1;
                    // busy drops once the full stop bit has been sent
                    if (bitDone)
                    begin
                        state <= txIdle;
                        busy  <= 1'b0;
                    end
                end
                default:
                begin
                    state <= txIdle;
                end
            endcase
        end
    end

    // LSB first, so shift right after each bit
    always_ff @(posedge pll_clk)
    begin
        if (loadByte)
        begin
            shiftReg <= wrByte;
        end
        else if (shiftBit)
        begin
            shiftReg <= shiftReg >> 1;
        end
    end

endmodule

/* design/readDataSelect.sv */
`timescale 1ns/1ps

module readDataSelect
(
    input  logic                          pll_clk,
    input  logic                          rst,
    input  hostPkg::busCycle              cycleType,
    input  logic [hostPkg::dataWidth-1:0] ioPage,
    input  logic [hostPkg::dataWidth-1:0] memByte,
    input  logic                          busy,
    output logic [hostPkg::dataWidth-1:0] readData,
    output logic                          readValid
);
    import hostPkg::*;
    import memMapPkg::*;

    busCycle              cycleDelay;
    logic [dataWidth-1:0] pageDelay;
    logic [dataWidth-1:0] selByte;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Alignment with the memory read
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge pll_clk)
    begin
        if (rst)
        begin
            cycleDelay <= idle;
        end
        else
        begin
            cycleDelay <= cycleType;
        end
    end

    always_ff @(posedge pll_clk)
    begin
        pageDelay <= ioPage;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Read byte mux
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb
    begin
        case (cycleDelay)
            memRead: selByte = memByte;
            // Status page returns busy in bit 0, other pages read as zero
            ioRead:  selByte = (pageDelay == ioStatusPage) ? {7'b0, busy} : 8'h00;
            intAck:  selByte = intVector;
            default: selByte = 8'h00;
        endcase
    end

    // Output register with one valid pulse per read
    always_ff @(posedge pll_clk)
    begin
        if (rst)
        begin
            readValid <= 1'b0;
        end
        else
        begin
            readValid <= (cycleDelay == memRead) || (cycleDelay == ioRead) ||
                         (cycleDelay == intAck);
        end
    end

    always_ff @(posedge pll_clk)
    begin
        readData <= selByte;
    end

endmodule

/* design/host.sv */
`timescale 1ns/1ps

module host
(
    input  logic                          pll_clk,
    input  logic                          rst,
    input  logic                          nM1,
    input  logic                          nMreq,
    input  logic                          nIorq,
    input  logic                          nRd,
    input  logic                          nWr,
    input  logic [hostPkg::addrWidth-1:0] address,
    input  logic [hostPkg::dataWidth-1:0] writeData,
    output logic [hostPkg::dataWidth-1:0] readData,
    output logic                          readValid,
    output logic                          serialOut
);
    import hostPkg::*;

    // Decode stage outputs
    busCycle                  cycleType;
    logic                     ramSelect;
    logic [memIndexWidth-1:0] memIndex;
    logic [dataWidth-1:0]     ioPage;
    logic [dataWidth-1:0]     wrByte;
    logic                     ramWrite;
    logic                     txWrite;

    // Execute stage outputs
    logic [dataWidth-1:0]     memByte;
    logic                     busy;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Decode
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    busCycleDecode busCycleDecode_i (
        .pll_clk   (pll_clk),
        .rst       (rst),
        .nM1       (nM1),
        .nMreq     (nMreq),
        .nIorq     (nIorq),
        .nRd       (nRd),
        .nWr       (nWr),
        .address   (address),
        .writeData (writeData),
        .cycleType (cycleType),
        .ramSelect (ramSelect),
        .memIndex  (memIndex),
        .ioPage    (ioPage),
        .wrByte    (wrByte),
        .ramWrite  (ramWrite),
        .txWrite   (txWrite)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Execute
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // ROM and RAM of 512 bytes each
    memoryBlock memoryBlock_i (
        .pll_clk   (pll_clk),
        .memIndex  (memIndex),
        .ramSelect (ramSelect),
        .ramWrite  (ramWrite),
        .wrByte    (wrByte),
        .memByte   (memByte)
    );

    // Transmit-only serial port
    serialTx serialTx_i (
        .pll_clk   (pll_clk),
        .rst       (rst),
        .txWrite   (txWrite),
        .wrByte    (wrByte),
        .serialOut (serialOut),
        .busy      (busy)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Result
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    readDataSelect readDataSelect_i (
        .pll_clk   (pll_clk),
        .rst       (rst),
        .cycleType (cycleType),
        .ioPage    (ioPage),
        .memByte   (memByte),
        .busy      (busy),
        .readData  (readData),
        .readValid (readValid)
    );

endmodule

/* dv/host_asserts.sv */
`timescale 1ns/1ps

module host_asserts
(
    input logic pll_clk,
    input logic rst,
    input logic nM1,
    input logic nMreq,
    input logic nIorq,
    input logic nRd,
    input logic nWr,
    input logic readValid,
    input logic serialOut,
    input logic busy
);
    logic readStrobe;

    // Memory read, IO read or interrupt acknowledge on the pins
    assign readStrobe = (!nMreq && !nRd) || (!nIorq && !nRd) || (!nIorq && !nM1);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Read latency
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Pins taken at edge N raise readValid after edge N+2 so it shows here at N+3
    readValidAfterRead: assert property (@(posedge pll_clk) disable iff (rst)
        readStrobe |-> ##3 readValid)
        else $error("readValid missing two cycles after a read strobe");

    readValidOnlyForRead: assert property (@(posedge pll_clk) disable iff (rst)
        readValid |-> $past(readStrobe, 3))
        else $error("readValid high without a read strobe two cycles earlier");

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Serial line and strobes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Line rests high between frames
    serialIdleHigh: assert property (@(posedge pll_clk) disable iff (rst)
        !busy |-> serialOut)
        else $error("serialOut low while no frame is in progress");

    strobesExclusive: assert property (@(posedge pll_clk)
        !(!nRd && !nWr))
        else $error("nRd and nWr low together");

endmodule

// busy is the transmitter flag inside host
bind host host_asserts host_asserts_i (
    .pll_clk   (pll_clk),
    .rst       (rst),
    .nM1       (nM1),
    .nMreq     (nMreq),
    .nIorq     (nIorq),
    .nRd       (nRd),
    .nWr       (nWr),
    .readValid (readValid),
    .serialOut (serialOut),
    .busy      (busy)
);

/* dv/hostTb.sv */
`timescale 1ns/1ps

module hostTb;
    import hostPkg::*;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Run constants
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int          clkPeriodNs  = 8;
    localparam int          driveDelayNs = 1;
    localparam int          resetCycles  = 4;
    localparam int          maxGapCycles = 2;
    localparam logic [31:0] randSeed     = 32'h3cfb;
    localparam string       testsPath    = "dv/host_tests.txt";

    // Operation codes of the tests file
    localparam logic [3:0] opMemRead  = 4'h0;
    localparam logic [3:0] opMemWrite = 4'h1;
    localparam logic [3:0] opIoRead   = 4'h2;
    localparam logic [3:0] opIoWrite  = 4'h3;
    localparam logic [3:0] opIntAck   = 4'h4;
    localparam logic [3:0] opIdle     = 4'h5;

    // DUT pins
    logic                 pll_clk;
    logic                 rst;
    logic                 nM1;
    logic                 nMreq;
    logic                 nIorq;
    logic                 nRd;
    logic                 nWr;
    logic [addrWidth-1:0] address;
    logic [dataWidth-1:0] writeData;
    logic [dataWidth-1:0] readData;
    logic                 readValid;
    logic                 serialOut;

    // Operations as loaded from the tests file
    logic [3:0]           opList   [$];
    logic [addrWidth-1:0] addrList [$];
    logic [dataWidth-1:0] dataList [$];
    logic [dataWidth-1:0] expList  [$];

    // Bytes still owed by the DUT in the order they were requested
    logic [dataWidth-1:0] readExpQ   [$];
    logic [dataWidth-1:0] serialExpQ [$];

    int frameCount   = 0;
    bit testsLoaded  = 1'b0;
    int readErrors   = 0;
    int serialErrors = 0;
    int otherErrors  = 0;

    host host_i (
        .pll_clk   (pll_clk),
        .rst       (rst),
        .nM1       (nM1),
        .nMreq     (nMreq),
        .nIorq     (nIorq),
        .nRd       (nRd),
        .nWr       (nWr),
        .address   (address),
        .writeData (writeData),
        .readData  (readData),
        .readValid (readValid),
        .serialOut (serialOut)
    );

    always #(clkPeriodNs / 2) pll_clk = ~pll_clk;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Bus driving
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // All strobes released and the bus quiet
    task automatic driveIdle();
        nM1       = 1'b1;
        nMreq     = 1'b1;
        nIorq     = 1'b1;
        nRd       = 1'b1;
        nWr       = 1'b1;
        address   = '0;
        writeData = '0;
    endtask

    // Lines starting with # are comments and the rest hold op, address, data and expected
    task automatic loadTests();
        int                   fd;
        int                   fields;
        string                line;
        logic [3:0]           op;
        logic [addrWidth-1:0] addr;
        logic [dataWidth-1:0] data;
        logic [dataWidth-1:0] expByte;
        fd = $fopen(testsPath, "r");
        if (fd == 0)
        begin
            $display("Could not open the tests file %s", testsPath);
        end
        else
        begin
            while ($fgets(line, fd) != 0)
            begin
                if ((line.len() > 0) && (line.getc(0) != "#"))
                begin
                    fields = $sscanf(line, "%h %h %h %h", op, addr, data, expByte);
                    if (fields == 4)
                    begin
                        opList.push_back(op);
                        addrList.push_back(addr);
                        dataList.push_back(data);
                        expList.push_back(expByte);
                        // Serial writes flagged in the expected column send a frame
                        if ((op == opIoWrite) && (expByte != 8'h00))
                        begin
                            frameCount++;
                        end
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // One bus operation with strobes held across exactly one sampling edge
    task automatic runOperation(input int idx);
        logic [3:0] op;
        int         cycles;
        int         gap;
        op        = opList[idx];
        cycles    = 1;
        address   = addrList[idx];
        writeData = dataList[idx];
        case (op)
            opMemRead:
            begin
                nMreq = 1'b0;
                nRd   = 1'b0;
                readExpQ.push_back(expList[idx]);
            end
            opMemWrite:
            begin
                nMreq = 1'b0;
                nWr   = 1'b0;
            end
            opIoRead:
            begin
                nIorq = 1'b0;
                nRd   = 1'b0;
                readExpQ.push_back(expList[idx]);
            end
            opIoWrite:
            begin
                nIorq = 1'b0;
                nWr   = 1'b0;
                if (expList[idx] != 8'h00)
                begin
                    serialExpQ.push_back(dataList[idx]);
                end
            end
            opIntAck:
            begin
                nM1   = 1'b0;
                nIorq = 1'b0;
                readExpQ.push_back(expList[idx]);
            end
            opIdle:
            begin
                // Address column is the number of quiet cycles
                cycles  = int'(addrList[idx]);
                address = '0;
            end
            default:
            begin
                $display("Unknown operation code %0h on test line %0d", op, idx);
                otherErrors++;
            end
        endcase
        repeat (cycles) @(posedge pll_clk);
        #(driveDelayNs);
        driveIdle();
        // Zero gap keeps the next cycle back to back
        gap = int'($urandom_range(maxGapCycles, 0));
        // The read after a memory write is sampled in the very next cycle
        if (op == opMemWrite)
        begin
            gap = 0;
        end
        if (gap > 0)
        begin
            repeat (gap) @(posedge pll_clk);
            #(driveDelayNs);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Response checking
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Every readValid pulse answers the oldest outstanding read
    always @(posedge pll_clk)
    begin : readCheck
        logic [dataWidth-1:0] expected;
        if (!rst && readValid)
        begin
            if (readExpQ.size() == 0)
            begin
                $display("readValid pulsed while no read was outstanding");
                otherErrors++;
            end
            else
            begin
                expected = readExpQ.pop_front();
                assert (readData == expected)
                else
                begin
                    $display("CHECK FAILED readData: got 0x%02h, expected 0x%02h",
                             readData, expected);
                    readErrors++;
                end
            end
        end
    end

    // 8N1 receiver sampling on the falling clock near mid-bit
    always
    begin : serialMonitor
        logic [dataWidth-1:0] rxByte;
        logic [dataWidth-1:0] expected;
        @(negedge serialOut);
        repeat (serialBitCycles / 2) @(negedge pll_clk);
        if (serialOut !== 1'b0)
        begin
            $display("Serial start bit did not stay low up to mid-bit");
            serialErrors++;
        end
        else
        begin
            rxByte = '0;
            for (int i = 0; i < dataWidth; i++)
            begin
                repeat (serialBitCycles) @(negedge pll_clk);
                rxByte = {serialOut, rxByte[dataWidth-1:1]};  // LSB arrives first
            end
            repeat (serialBitCycles) @(negedge pll_clk);
            if (serialOut !== 1'b1)
            begin
                $display("Serial stop bit was not high");
                serialErrors++;
            end
            if (serialExpQ.size() == 0)
            begin
                $display("Serial frame 0x%02h arrived with no serial write pending", rxByte);
                serialErrors++;
            end
            else
            begin
                expected = serialExpQ.pop_front();
                assert (rxByte == expected)
                else
                begin
                    $display("CHECK FAILED serialOut: got 0x%02h, expected 0x%02h",
                             rxByte, expected);
                    serialErrors++;
                end
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Run control
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Budget of 12 bit times per test line and per expected frame
    initial
    begin : watchdog
        longint timeoutNs;
        wait (testsLoaded);
        timeoutNs = longint'(opList.size() + frameCount) * 12 * serialBitCycles * clkPeriodNs;
        #(timeoutNs);
        $display("Run timed out after %0d ns with responses still outstanding", timeoutNs);
        $display("test failed");
        $finish;
    end

    initial
    begin
        pll_clk = 1'b0;
        rst     = 1'b1;
        driveIdle();
        void'($urandom(randSeed));
        loadTests();
        if (opList.size() == 0)
        begin
            $display("No operations could be read from %s", testsPath);
            otherErrors++;
        end
        else
        begin
            testsLoaded = 1'b1;
            repeat (resetCycles) @(posedge pll_clk);
            #(driveDelayNs);
            rst = 1'b0;
            foreach (opList[i])
            begin
                runOperation(i);
            end
            // Let outstanding reads and frames come back
            while ((readExpQ.size() != 0) || (serialExpQ.size() != 0))
            begin
                @(posedge pll_clk);
            end
            repeat (4) @(posedge pll_clk);
        end
        $display("Errors: read %0d, serial %0d, other %0d",
                 readErrors, serialErrors, otherErrors);
        if ((readErrors + serialErrors + otherErrors) == 0)
        begin
            $display("test passed");
        end
        else
        begin
            $display("test failed");
        end
        $finish;
    end

endmodule

/* dv/host_tests.txt */
# op: 0 mem read, 1 mem write, 2 io read, 3 io write, 4 int ack, 5 idle (address = cycles)
# columns in hex: op address data expected; io write expected is 1 for a frame, 0 for none
0 0000 00 ff
0 0012 00 ed
0 0145 00 e0
0 04a7 00 58
0 1d80 00 25
0 f412 00 ed
1 0234 a5 00
0 0234 00 a5
0 0634 00 a5
0 fe34 00 a5
1 03ff 3c 00
0 03ff 00 3c
1 0012 77 00
0 0012 00 ed
4 0000 00 80
2 0500 00 00
2 0100 00 00
3 0000 55 01
2 0200 00 01
3 0000 c3 00
5 0078 00 00
2 0200 00 00
3 0100 11 00
3 0011 9e 01
5 0064 00 00
2 0200 00 00

/* verilog.f */
design/hostPkg.sv
design/memMapPkg.sv
design/busCycleDecode.sv
design/memoryBlock.sv
design/serialTx.sv
design/readDataSelect.sv
design/host.sv
dv/host_asserts.sv
dv/hostTb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the host testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module hostTb -f verilog.f -Mdir obj_dir

# Verdict comes from the testbench output
output="$(./obj_dir/VhostTb 2>&1)" || true
echo "$output"

if grep -qx "test passed" <<< "$output"; then
    exit 0
fi
exit 1
